// ==== files.f ====
hw/mul_pkg.sv
hw/mul_step_if.sv
hw/mul_ctrl.sv
hw/booth_array.sv
hw/mul_accum.sv
hw/mul_unit.sv
tests/mul_unit_assert.sv
tests/mul_unit_tb.sv

// ==== tests/mul_unit_tb.sv ====
module mul_unit_tb;

	// expected outputs of one operation
	typedef struct packed {
		mul_pkg::word_t hi;
		mul_pkg::word_t lo;
		logic           n;
		logic           z;
	} result_t;

	logic           clk;
	logic           rst;
	mul_pkg::word_t a;
	mul_pkg::word_t b;
	mul_pkg::word_t c_hi;
	mul_pkg::word_t c_lo;
	logic           start;
	logic           sig;
	logic           long_op;
	logic           add_op;
	mul_pkg::word_t q_hi;
	mul_pkg::word_t q_lo;
	logic           n;
	logic           z;
	logic           rdy;

	logic [31:0] lfsr;     // random state
	result_t     exp_res;  // expected result of the op in flight
	int          issued;   // ops started by the stimulus
	int          checked;  // ops compared
	int          errors;

	mul_unit dut (
		.clk     (clk),
		.rst     (rst),
		.a       (a),
		.b       (b),
		.c_hi    (c_hi),
		.c_lo    (c_lo),
		.start   (start),
		.sig     (sig),
		.long_op (long_op),
		.add_op  (add_op),
		.q_hi    (q_hi),
		.q_lo    (q_lo),
		.n       (n),
		.z       (z),
		.rdy     (rdy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois lfsr, right shift, taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int nbits, output mul_pkg::word_t v);
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// q = a * b + c, widened to 64 bits and wrapped to the result width
	function automatic result_t ref_mac(input mul_pkg::word_t av, bv, chv, clv,
			input logic sv, lv, dv);
		logic [63:0] xa;
		logic [63:0] xb;
		logic [63:0] addend;
		logic [63:0] total;
		result_t     r;
		xa     = sv ? {{32{av[31]}}, av} : {32'h0, av};
		xb     = sv ? {{32{bv[31]}}, bv} : {32'h0, bv};
		addend = 64'h0;
		if (dv)
			addend = lv ? {chv, clv} : {32'h0, clv};
		total = xa * xb + addend;  // low 64 bits are exact for both signednesses
		r.hi  = lv ? total[63:32] : 32'h0;
		r.lo  = total[31:0];
		r.n   = lv ? total[63] : total[31];
		r.z   = (r.hi == 32'h0) && (r.lo == 32'h0);
		return r;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, want);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("CHECKS FAILED");
		$fatal(1, "no progress on %s", what);
	endtask

	// one operation, optionally with a stray start and flipped op bits while busy
	task automatic run_op(input mul_pkg::word_t av, bv, chv, clv,
			input logic sv, lv, dv, input logic poke);
		int edges;
		int guard;
		@(negedge clk);
		a       = av;
		b       = bv;
		c_hi    = chv;
		c_lo    = clv;
		sig     = sv;
		long_op = lv;
		add_op  = dv;
		start   = 1'b1;
		exp_res = ref_mac(av, bv, chv, clv, sv, lv, dv);
		issued++;
		@(posedge clk);                 // start sampled here
		@(negedge clk);
		check_val("rdy", rdy, 1'b0);
		edges = 0;
		while (!rdy) begin
			start   = poke && (edges == 10);
			sig     = (poke && edges == 10) ? ~sv : sv;
			long_op = (poke && edges == 10) ? ~lv : lv;
			add_op  = (poke && edges == 10) ? ~dv : dv;
			@(posedge clk);
			edges++;
			@(negedge clk);
			if (edges > 40)
				report_timeout("rdy after start");
		end
		check_val("latency", edges, 35);
		guard = 0;
		while (checked != issued) begin
			@(negedge clk);
			guard++;
			if (guard > 5)
				report_timeout("the comparison of the result");
		end
	endtask

	// comparison, sampled on falling edges where outputs are settled
	initial begin : compare
		int wait_cnt;
		forever begin
			wait_cnt = 0;
			while (issued == checked) begin
				@(negedge clk);
				wait_cnt++;
				if (wait_cnt > 500)
					report_timeout("a new operation");
			end
			wait_cnt = 0;
			while (rdy) begin
				@(negedge clk);
				wait_cnt++;
				if (wait_cnt > 5)
					report_timeout("rdy to fall");
			end
			wait_cnt = 0;
			while (!rdy) begin
				@(negedge clk);
				wait_cnt++;
				if (wait_cnt > 50)
					report_timeout("rdy to rise");
			end
			check_val("q_hi", q_hi, exp_res.hi);
			check_val("q_lo", q_lo, exp_res.lo);
			check_val("n", n, exp_res.n);
			check_val("z", z, exp_res.z);
			checked++;
		end
	end

	initial begin : stimulus
		mul_pkg::word_t ra;
		mul_pkg::word_t rb;
		mul_pkg::word_t rch;
		mul_pkg::word_t rcl;
		mul_pkg::word_t rbit;
		rst     = 1'b0;
		a       = '0;
		b       = '0;
		c_hi    = '0;
		c_lo    = '0;
		start   = 1'b0;
		sig     = 1'b0;
		long_op = 1'b0;
		add_op  = 1'b0;
		lfsr    = 32'd27;
		issued  = 0;
		checked = 0;
		errors  = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_val("rdy", rdy, 1'b1);    // reset state
		check_val("q_hi", q_hi, 0);
		check_val("q_lo", q_lo, 0);
		check_val("n", n, 0);
		check_val("z", z, 0);
		// extreme operands, long forms without c
		run_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h0, 1'b0, 1'b1, 1'b0, 1'b0);
		run_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
		run_op(32'h8000_0000, 32'h8000_0000, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
		run_op(32'h8000_0000, 32'hFFFF_FFFF, 32'h0, 32'h0, 1'b0, 1'b1, 1'b0, 1'b0);
		run_op(32'h8000_0000, 32'hFFFF_FFFF, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
		for (int i = 0; i < 12; i++) begin
			draw_bits(32, ra);
			draw_bits(32, rb);
			draw_bits(32, rch);         // c must be ignored
			draw_bits(32, rcl);
			draw_bits(1, rbit);
			run_op(ra, rb, rch, rcl, rbit[0], 1'b1, 1'b0, 1'b0);
		end
		// accumulating forms, short and long
		for (int i = 0; i < 12; i++) begin
			draw_bits(32, ra);
			draw_bits(32, rb);
			draw_bits(32, rch);
			draw_bits(32, rcl);
			draw_bits(2, rbit);
			run_op(ra, rb, rch, rcl, rbit[0], rbit[1], 1'b1, 1'b0);
		end
		// sums wrapping the result width
		run_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
			1'b0, 1'b1, 1'b1, 1'b0);
		run_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h1234_5678, 32'hFFFF_FFFF,
			1'b0, 1'b0, 1'b1, 1'b0);   // wraps to zero, q_hi still zero
		run_op(32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'h0000_0001,
			1'b1, 1'b1, 1'b1, 1'b0);   // -1 + 1 in SMLAL
		// flags
		run_op(32'h0, 32'hDEAD_BEEF, 32'h5555_AAAA, 32'h0F0F_F0F0,
			1'b1, 1'b1, 1'b0, 1'b0);   // z with no addend
		run_op(32'h0, 32'h1357_9BDF, 32'h0, 32'h7777_7777, 1'b0, 1'b0, 1'b0, 1'b0);
		run_op(32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0, 1'b0);
		run_op(32'h8000_0000, 32'h0000_0001, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		// stray start while busy
		draw_bits(32, ra);
		draw_bits(32, rb);
		draw_bits(32, rch);
		draw_bits(32, rcl);
		run_op(ra, rb, rch, rcl, 1'b1, 1'b1, 1'b1, 1'b1);
		run_op(rb, ra, rcl, rch, 1'b0, 1'b0, 1'b0, 1'b1);
		@(negedge clk);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== tests/mul_unit_assert.sv ====
module mul_ctrl_assert (
	input logic clk,
	input logic rst,
	input logic rdy,
	input logic load,    // registered strobes of the controller
	input logic step,
	input logic acc_en
);

	// at most one sequencing strobe in any cycle
	strobe_onehot: assert property (@(posedge clk) disable iff (!rst)
		$onehot0({load, step, acc_en}))
		else $error("load, step and acc_en are high together");

	// load comes from the edge that saw rdy high
	load_from_idle: assert property (@(posedge clk) disable iff (!rst)
		load |-> $past(rdy))
		else $error("load issued while the unit was busy");

	// the first step follows load directly
	load_then_step: assert property (@(posedge clk) disable iff (!rst)
		load |=> step)
		else $error("no step strobe after load");

	// result registered, unit idle again
	acc_then_rdy: assert property (@(posedge clk) disable iff (!rst)
		acc_en |=> rdy)
		else $error("rdy did not return after acc_en");

	// strobes run back to back from load to acc_en, rdy stays low throughout
	busy_while_strobing: assert property (@(posedge clk) disable iff (!rst)
		(load || step || acc_en) |-> !rdy)
		else $error("rdy high between load and acc_en");

endmodule

bind mul_ctrl mul_ctrl_assert u_ctrl_assert (
	.clk    (clk),
	.rst    (rst),
	.rdy    (rdy),
	.load   (load_r),
	.step   (step_r),
	.acc_en (acc_en_r)
);

// ==== hw/mul_unit.sv ====
module mul_unit (
	input  logic            clk,
	input  logic            rst,
	input  mul_pkg::word_t  a,        // multiplicand
	input  mul_pkg::word_t  b,        // multiplier
	input  mul_pkg::word_t  c_hi,     // accumulate high word
	input  mul_pkg::word_t  c_lo,     // accumulate low word
	input  logic            start,    // begin an operation when rdy is high
	input  logic            sig,      // signed operands
	input  logic            long_op,  // 64-bit result
	input  logic            add_op,   // accumulate c
	output mul_pkg::word_t  q_hi,
	output mul_pkg::word_t  q_lo,
	output logic            n,
	output logic            z,
	output logic            rdy       // idle, result valid
);

	// step controls from the sequencer to both datapath halves
	mul_step_if stp ();

	mul_pkg::dword_t product;         // booth result into the accumulator

	mul_ctrl u_ctrl (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.sig     (sig),
		.long_op (long_op),
		.add_op  (add_op),
		.rdy     (rdy),
		.stp     (stp.ctrl)
	);

	booth_array u_booth (
		.clk     (clk),
		.rst     (rst),
		.a       (a),
		.b       (b),
		.stp     (stp.booth),
		.product (product)
	);

	mul_accum u_accum (
		.clk     (clk),
		.rst     (rst),
		.product (product),
		.c_hi    (c_hi),
		.c_lo    (c_lo),
		.stp     (stp.accum),
		.q_hi    (q_hi),
		.q_lo    (q_lo),
		.n       (n),
		.z       (z)
	);

endmodule

// ==== hw/mul_accum.sv ====
module mul_accum (
	input  logic             clk,
	input  logic             rst,
	input  mul_pkg::dword_t  product,  // from the booth array, stable once steps end
	input  mul_pkg::word_t   c_hi,     // addend high word, long forms only
	input  mul_pkg::word_t   c_lo,     // addend low word
	mul_step_if.accum        stp,
	output mul_pkg::word_t   q_hi,
	output mul_pkg::word_t   q_lo,
	output logic             n,        // result negative
	output logic             z         // result zero
);

	mul_pkg::dword_t addend;   // selected c, or zero
	mul_pkg::dword_t sum;      // product + addend, modulo 2^64
	mul_pkg::dword_t res;      // sum cut to the result width
	logic            res_neg;  // top bit of the result width

	always_comb begin
		addend = '0;                     // MUL and the plain long forms
		if (stp.add_op) begin
			if (stp.long_op)
				addend = {c_hi, c_lo};   // UMLAL, SMLAL
			else
				addend = {{mul_pkg::word_w{1'b0}}, c_lo}; // MLA
		end
	end

	assign sum = product + addend;

	// short forms keep one word and clear the high half
	assign res = stp.long_op ? sum : {{mul_pkg::word_w{1'b0}}, sum[mul_pkg::word_w-1:0]};

	// n comes from bit 63 or bit 31 depending on the form
	assign res_neg = stp.long_op ? res[2*mul_pkg::word_w-1] : res[mul_pkg::word_w-1];

	// C and V are not produced here, the core leaves them unaffected

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			q_hi <= '0;
			q_lo <= '0;
			n    <= 1'b0;
			z    <= 1'b0;
		end else if (stp.acc_en) begin
			q_hi <= res[2*mul_pkg::word_w-1 -: mul_pkg::word_w];
			q_lo <= res[mul_pkg::word_w-1:0];
			n    <= res_neg;
			z    <= ~|res;   // high half is zero in short forms anyway
		end
	end

	// q, n and z hold until the next acc_en

endmodule

// ==== hw/booth_array.sv ====
module booth_array (
	input  logic             clk,
	input  logic             rst,
	input  mul_pkg::word_t   a,        // multiplicand
	input  mul_pkg::word_t   b,        // multiplier
	mul_step_if.booth        stp,
	output mul_pkg::dword_t  product   // low two words of the booth register
);

	// operands widened by one bit so that unsigned values are positive in two's complement
	logic [mul_pkg::ext_w-1:0] a_ext;
	logic [mul_pkg::ext_w-1:0] b_ext;

	logic [mul_pkg::ext_w-1:0]  mcand;     // captured multiplicand
	logic [mul_pkg::prod_w-1:0] prod;      // {partial sum, remaining multiplier bits}
	logic                       q_m1;      // previous multiplier bit for recoding

	logic [mul_pkg::ext_w-1:0] upper;      // partial sum half
	logic [mul_pkg::ext_w-1:0] upper_nxt;  // after add, sub or hold

	// extension bit is the sign bit for signed ops, zero otherwise
	assign a_ext = {stp.sig & a[mul_pkg::word_w-1], a};
	assign b_ext = {stp.sig & b[mul_pkg::word_w-1], b};

	assign upper = prod[mul_pkg::prod_w-1 -: mul_pkg::ext_w];

	// radix-2 recoding on {current bit, previous bit}
	always_comb begin
		case ({prod[0], q_m1})
			2'b10:   upper_nxt = upper - mcand;  // start of a run of ones
			2'b01:   upper_nxt = upper + mcand;  // end of a run of ones
			default: upper_nxt = upper;          // inside a run, nothing to do
		endcase
	end

	// the partial sum stays within the multiplicand magnitude, so ext_w bits never overflow

	always_ff @(posedge clk) begin
		if (stp.load)
			mcand <= a_ext; // a is only sampled here
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			prod <= '0;
			q_m1 <= 1'b0;
		end else if (stp.load) begin
			// multiplier in the low half, partial sum cleared
			prod <= {{mul_pkg::ext_w{1'b0}}, b_ext};
			q_m1 <= 1'b0;
		end else if (stp.step) begin
			// arithmetic shift right of {upper_nxt, lower half}
			prod <= {upper_nxt[mul_pkg::ext_w-1], upper_nxt, prod[mul_pkg::ext_w-1:1]};
			q_m1 <= prod[0];                 // consumed bit becomes the previous bit
		end
	end

	// after booth_steps shifts the full ext_w x ext_w product sits in prod,
	// only the low 2*word_w bits are meaningful
	assign product = prod[2*mul_pkg::word_w-1:0];

endmodule

// ==== hw/mul_ctrl.sv ====
module mul_ctrl (
	input  logic     clk,
	input  logic     rst,
	input  logic     start,    // request, only honoured while idle
	input  logic     sig,
	input  logic     long_op,
	input  logic     add_op,
	output logic     rdy,      // high while idle
	mul_step_if.ctrl stp
);

	typedef enum logic [1:0] {
		st_idle,   // waiting for start
		st_booth,  // issuing step strobes
		st_accum   // single acc_en cycle
	} state_t;

	state_t state;

	logic [mul_pkg::cnt_w-1:0] cnt; // step strobes issued so far

	// registered strobes, so the datapath sees clean one-cycle pulses
	logic load_r;
	logic step_r;
	logic acc_en_r;

	// operation bits latched at start
	logic sig_r;
	logic long_r;
	logic add_r;

	assign stp.load    = load_r;
	assign stp.step    = step_r;
	assign stp.acc_en  = acc_en_r;
	assign stp.sig     = sig_r;
	assign stp.long_op = long_r;
	assign stp.add_op  = add_r;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= st_idle;
			cnt      <= '0;
			rdy      <= 1'b1;  // ready straight out of reset
			load_r   <= 1'b0;
			step_r   <= 1'b0;
			acc_en_r <= 1'b0;
			sig_r    <= 1'b0;
			long_r   <= 1'b0;
			add_r    <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						sig_r  <= sig;       // freeze op bits for the datapath
						long_r <= long_op;
						add_r  <= add_op;
						load_r <= 1'b1;      // one-cycle operand capture
						rdy    <= 1'b0;      // falls on the sampling edge
						cnt    <= '0;
						state  <= st_booth;
					end
				end
				st_booth: begin
					load_r <= 1'b0;
					if (cnt == mul_pkg::step_last) begin
						// all booth_steps strobes issued, hand over to accumulate
						step_r   <= 1'b0;
						acc_en_r <= 1'b1;
						state    <= st_accum;
					end else begin
						step_r <= 1'b1;
						cnt    <= cnt + 1'b1;
					end
				end
				st_accum: begin
					acc_en_r <= 1'b0;
					rdy      <= 1'b1;        // result registered on this same edge
					state    <= st_idle;
				end
				default: begin
					state <= st_idle;        // recover from an illegal encoding
				end
			endcase
		end
	end

endmodule

// ==== hw/mul_step_if.sv ====
interface mul_step_if;

	// sequencing strobes, at most one high per cycle
	logic load;    // capture operands into the booth array
	logic step;    // one recode, add/sub and shift
	logic acc_en;  // register the final result and flags

	// operation bits, held steady by the controller for the whole operation
	logic sig;     // signed operands
	logic long_op; // two word result
	logic add_op;  // add c

	modport ctrl (
		output load, step, acc_en,
		output sig, long_op, add_op
	);

	modport booth (
		input load, step, sig
	);

	modport accum (
		input acc_en, long_op, add_op
	);

endinterface

// ==== hw/mul_pkg.sv ====
package mul_pkg;

	// datapath widths
	localparam int word_w = 32;               // architectural word
	localparam int ext_w  = word_w + 1;       // one extra bit for sign or zero extension
	localparam int prod_w = 2 * ext_w;        // booth product register, upper and lower half

	// Booth sequencing, one recoding step per extended operand bit
	localparam int booth_steps = ext_w;
	localparam int cnt_w       = $clog2(booth_steps + 1);

	// counter value seen on the edge after the final step strobe is issued
	localparam logic [cnt_w-1:0] step_last = cnt_w'(booth_steps);

	// single and double result words
	typedef logic [word_w-1:0]   word_t;
	typedef logic [2*word_w-1:0] dword_t;

endpackage
